//--- hw/mpu_pkg.sv
// Shared types and the default PMA table for the MPU
// Region bounds are word addresses, low bound inclusive and high bound exclusive

`default_nettype none

package mpu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [29:0] word_addr_t;
  typedef logic [31:0] data_t;

  // Bit 0 bufferable, bit 1 cacheable
  typedef logic [1:0] memtype_t;

  typedef logic [4:0] pma_attr_t;

  // Attribute bit positions
  localparam int unsigned ATTR_MAIN       = 0;
  localparam int unsigned ATTR_BUFFERABLE = 1;
  localparam int unsigned ATTR_CACHEABLE  = 2;
  localparam int unsigned ATTR_ATOMIC     = 3;
  localparam int unsigned ATTR_EXEC       = 4;

  typedef enum logic [1:0] {
    MPU_OK          = 2'd0,
    MPU_ERR_NOMATCH = 2'd1,
    MPU_ERR_PERM    = 2'd2
  } mpu_status_e;

  typedef enum logic [1:0] {
    MPU_IDLE     = 2'd0,
    MPU_DRAIN    = 2'd1,
    MPU_ERR_RESP = 2'd2
  } mpu_state_e;

  localparam int unsigned MAX_REGIONS = 16;

  ////////////////////////////////////////////////////////////
  // Default region table
  ////////////////////////////////////////////////////////////

  localparam int unsigned DEFAULT_NUM_REGIONS = 4;

  // Region 2 starts at byte 0x4000_0000, region 3 at byte 0x8000_0000
  localparam word_addr_t [DEFAULT_NUM_REGIONS-1:0] DEFAULT_REGION_LOW = {
    30'h2000_0000, 30'h1000_0000, 30'h0000_2000, 30'h0000_0000
  };

  localparam word_addr_t [DEFAULT_NUM_REGIONS-1:0] DEFAULT_REGION_HIGH = {
    30'h2000_1000, 30'h1000_1000, 30'h0000_8000, 30'h0000_4000
  };

  localparam pma_attr_t [DEFAULT_NUM_REGIONS-1:0] DEFAULT_REGION_ATTR = {
    pma_attr_t'(0),
    pma_attr_t'(1 << ATTR_BUFFERABLE),
    pma_attr_t'((1 << ATTR_MAIN) | (1 << ATTR_ATOMIC)),
    pma_attr_t'((1 << ATTR_MAIN) | (1 << ATTR_CACHEABLE) | (1 << ATTR_ATOMIC) |
                (1 << ATTR_EXEC))
  };

endpackage

`default_nettype wire

//--- hw/pma_region_decode.sv
// Combinational PMA lookup, lowest matching region index wins
// NUM_REGIONS must not exceed mpu_pkg::MAX_REGIONS

`timescale 1ns/1ns
`default_nettype none

module pma_region_decode #(
  parameter int unsigned NUM_REGIONS = mpu_pkg::DEFAULT_NUM_REGIONS,
  parameter mpu_pkg::word_addr_t [NUM_REGIONS-1:0] REGION_LOW =
    mpu_pkg::DEFAULT_REGION_LOW,
  parameter mpu_pkg::word_addr_t [NUM_REGIONS-1:0] REGION_HIGH =
    mpu_pkg::DEFAULT_REGION_HIGH,
  parameter mpu_pkg::pma_attr_t [NUM_REGIONS-1:0] REGION_ATTR =
    mpu_pkg::DEFAULT_REGION_ATTR
) (
  input  wire mpu_pkg::addr_t                     core_addr_i,
  input  wire logic                               core_exec_i,
  input  wire logic                               core_atomic_i,
  output logic                                    pma_err_o,
  output mpu_pkg::mpu_status_e                    pma_status_o,
  output mpu_pkg::memtype_t                       pma_memtype_o,
  output logic [$clog2(mpu_pkg::MAX_REGIONS)-1:0] region_hit_index_o,
  output logic                                    region_hit_o
);

  localparam int unsigned IDX_W = $clog2(mpu_pkg::MAX_REGIONS);

  mpu_pkg::word_addr_t word_addr;
  mpu_pkg::pma_attr_t  hit_attr;
  logic [IDX_W-1:0]    hit_idx;
  logic                hit;
  logic                perm_err;

  // Regions are word granular, byte offset is ignored
  assign word_addr = core_addr_i[31:2];

  ////////////////////////////////////////////////////////////
  // Region scan
  ////////////////////////////////////////////////////////////

  always_comb begin
    hit      = 1'b0;
    hit_idx  = '0;
    hit_attr = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      // First match only, later overlapping regions are shadowed
      if (!hit && (REGION_LOW[i] <= word_addr) && (word_addr < REGION_HIGH[i])) begin
        hit      = 1'b1;
        hit_idx  = IDX_W'(i);
        hit_attr = REGION_ATTR[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Permission check
  ////////////////////////////////////////////////////////////

  assign perm_err = hit &&
                    ((core_exec_i && !hit_attr[mpu_pkg::ATTR_EXEC]) ||
                     (core_atomic_i && !hit_attr[mpu_pkg::ATTR_ATOMIC]));

  assign pma_err_o = !hit || perm_err;

  always_comb begin
    if (!hit) begin
      pma_status_o = mpu_pkg::MPU_ERR_NOMATCH;
    end else if (perm_err) begin
      pma_status_o = mpu_pkg::MPU_ERR_PERM;
    end else begin
      pma_status_o = mpu_pkg::MPU_OK;
    end
  end

  // Memory type is only meaningful for forwarded requests
  assign pma_memtype_o = pma_err_o ? '0 :
                         {hit_attr[mpu_pkg::ATTR_CACHEABLE],
                          hit_attr[mpu_pkg::ATTR_BUFFERABLE]};

  assign region_hit_index_o = hit_idx;
  assign region_hit_o       = hit;

endmodule

`default_nettype wire

//--- hw/mpu_trans_gate.sv
// Forwards allowed requests with no added latency, swallows denied ones
// A denied request blocks core and bus until its error response is sent

`timescale 1ns/1ns
`default_nettype none

module mpu_trans_gate #(
  parameter int unsigned MAX_OUTSTANDING = 4
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n_i,
  // Core request
  input  wire logic                 core_req_valid_i,
  input  wire mpu_pkg::addr_t       core_addr_i,
  input  wire logic                 core_we_i,
  input  wire mpu_pkg::data_t       core_wdata_i,
  output logic                      core_req_ready_o,
  // From the region decoder
  input  wire logic                 pma_err_i,
  input  wire mpu_pkg::mpu_status_e pma_status_i,
  input  wire mpu_pkg::memtype_t    pma_memtype_i,
  // Bus request
  output logic                      bus_req_valid_o,
  output mpu_pkg::addr_t            bus_addr_o,
  output mpu_pkg::memtype_t         bus_memtype_o,
  output logic                      bus_we_o,
  output mpu_pkg::data_t            bus_wdata_o,
  input  wire logic                 bus_req_ready_i,
  input  wire logic                 bus_resp_valid_i,
  // Local error response
  output logic                      err_resp_valid_o,
  output mpu_pkg::mpu_status_e      err_status_o,
  output mpu_pkg::mpu_state_e       state_o
);

  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  mpu_pkg::mpu_state_e  state_q;
  mpu_pkg::mpu_state_e  state_d;
  mpu_pkg::mpu_status_e err_status_q;
  logic [CNT_W-1:0]     cnt_q;
  logic                 in_idle;
  logic                 cnt_full;
  logic                 err_accept;
  logic                 bus_hs;

  assign in_idle  = (state_q == mpu_pkg::MPU_IDLE);
  assign cnt_full = (cnt_q == CNT_W'(MAX_OUTSTANDING));

  ////////////////////////////////////////////////////////////
  // Request gating
  ////////////////////////////////////////////////////////////

  assign bus_req_valid_o = in_idle && core_req_valid_i && !pma_err_i && !cnt_full;

  // Denied requests are taken at once, allowed ones wait for the bus
  assign core_req_ready_o = in_idle && (pma_err_i || (bus_req_ready_i && !cnt_full));

  assign bus_addr_o    = core_addr_i;
  assign bus_memtype_o = pma_memtype_i;
  assign bus_we_o      = core_we_i;
  assign bus_wdata_o   = core_wdata_i;

  assign bus_hs     = bus_req_valid_o && bus_req_ready_i;
  assign err_accept = in_idle && core_req_valid_i && pma_err_i;

  ////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (bus_hs && !bus_resp_valid_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (!bus_hs && bus_resp_valid_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Error FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      mpu_pkg::MPU_IDLE: begin
        if (err_accept) begin
          state_d = (cnt_q != '0) ? mpu_pkg::MPU_DRAIN : mpu_pkg::MPU_ERR_RESP;
        end
      end
      mpu_pkg::MPU_DRAIN: begin
        // Wait for all earlier bus responses
        if (cnt_q == '0) begin
          state_d = mpu_pkg::MPU_ERR_RESP;
        end
      end
      mpu_pkg::MPU_ERR_RESP: begin
        state_d = mpu_pkg::MPU_IDLE;
      end
      default: begin
        state_d = mpu_pkg::MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= mpu_pkg::MPU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Status of the denied request, held until its response
  always_ff @(posedge clk) begin
    if (err_accept) begin
      err_status_q <= pma_status_i;
    end
  end

  assign err_resp_valid_o = (state_q == mpu_pkg::MPU_ERR_RESP);
  assign err_status_o     = err_status_q;
  assign state_o          = state_q;

endmodule

`default_nettype wire

//--- hw/mpu_resp_merge.sv
// Combines bus and local error responses into the core response
// Relies on the gate FSM to keep the two sources apart in time

`timescale 1ns/1ns
`default_nettype none

module mpu_resp_merge (
  // Bus response
  input  wire logic                 bus_resp_valid_i,
  input  wire mpu_pkg::data_t       bus_resp_rdata_i,
  // Local error response
  input  wire logic                 err_resp_valid_i,
  input  wire mpu_pkg::mpu_status_e err_status_i,
  // Core response
  output logic                      core_resp_valid_o,
  output mpu_pkg::data_t            core_resp_rdata_o,
  output mpu_pkg::mpu_status_e      core_resp_status_o
);

  ////////////////////////////////////////////////////////////
  // Source select
  ////////////////////////////////////////////////////////////

  assign core_resp_valid_o = bus_resp_valid_i || err_resp_valid_i;

  always_comb begin
    if (err_resp_valid_i) begin
      // Denied access never returns data
      core_resp_rdata_o  = '0;
      core_resp_status_o = err_status_i;
    end else if (bus_resp_valid_i) begin
      core_resp_rdata_o  = bus_resp_rdata_i;
      core_resp_status_o = mpu_pkg::MPU_OK;
    end else begin
      core_resp_rdata_o  = '0;
      core_resp_status_o = mpu_pkg::MPU_OK;
    end
  end

endmodule

`default_nettype wire

//--- hw/mpu_top.sv
// MPU between core load/store port and system bus, fixed PMA table
// No back-pressure on either response side

`timescale 1ns/1ns
`default_nettype none

module mpu_top #(
  parameter int unsigned NUM_REGIONS = mpu_pkg::DEFAULT_NUM_REGIONS,
  parameter mpu_pkg::word_addr_t [NUM_REGIONS-1:0] REGION_LOW =
    mpu_pkg::DEFAULT_REGION_LOW,
  parameter mpu_pkg::word_addr_t [NUM_REGIONS-1:0] REGION_HIGH =
    mpu_pkg::DEFAULT_REGION_HIGH,
  parameter mpu_pkg::pma_attr_t [NUM_REGIONS-1:0] REGION_ATTR =
    mpu_pkg::DEFAULT_REGION_ATTR,
  parameter int unsigned MAX_OUTSTANDING = 4
) (
  input  wire logic            clk,
  input  wire logic            rst_n_i,
  // Core request
  input  wire logic            core_req_valid_i,
  input  wire mpu_pkg::addr_t  core_addr_i,
  input  wire logic            core_exec_i,
  input  wire logic            core_atomic_i,
  input  wire logic            core_we_i,
  input  wire mpu_pkg::data_t  core_wdata_i,
  output logic                 core_req_ready_o,
  // Core response
  output logic                 core_resp_valid_o,
  output mpu_pkg::data_t       core_resp_rdata_o,
  output mpu_pkg::mpu_status_e core_resp_status_o,
  // Bus request
  output logic                 bus_req_valid_o,
  output mpu_pkg::addr_t       bus_addr_o,
  output mpu_pkg::memtype_t    bus_memtype_o,
  output logic                 bus_we_o,
  output mpu_pkg::data_t       bus_wdata_o,
  input  wire logic            bus_req_ready_i,
  // Bus response
  input  wire logic            bus_resp_valid_i,
  input  wire mpu_pkg::data_t  bus_resp_rdata_i,
  // Observation
  output mpu_pkg::mpu_state_e  state_o
);

  logic                                    pma_err;
  mpu_pkg::mpu_status_e                    pma_status;
  mpu_pkg::memtype_t                       pma_memtype;
  logic                                    err_resp_valid;
  mpu_pkg::mpu_status_e                    err_status;

  pma_region_decode #(
    .NUM_REGIONS (NUM_REGIONS),
    .REGION_LOW  (REGION_LOW),
    .REGION_HIGH (REGION_HIGH),
    .REGION_ATTR (REGION_ATTR)
  ) u_decode (
    .core_addr_i        (core_addr_i),
    .core_exec_i        (core_exec_i),
    .core_atomic_i      (core_atomic_i),
    .pma_err_o          (pma_err),
    .pma_status_o       (pma_status),
    .pma_memtype_o      (pma_memtype),
    .region_hit_index_o (),
    .region_hit_o       ()
  );

  mpu_trans_gate #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_gate (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .core_req_valid_i (core_req_valid_i),
    .core_addr_i      (core_addr_i),
    .core_we_i        (core_we_i),
    .core_wdata_i     (core_wdata_i),
    .core_req_ready_o (core_req_ready_o),
    .pma_err_i        (pma_err),
    .pma_status_i     (pma_status),
    .pma_memtype_i    (pma_memtype),
    .bus_req_valid_o  (bus_req_valid_o),
    .bus_addr_o       (bus_addr_o),
    .bus_memtype_o    (bus_memtype_o),
    .bus_we_o         (bus_we_o),
    .bus_wdata_o      (bus_wdata_o),
    .bus_req_ready_i  (bus_req_ready_i),
    .bus_resp_valid_i (bus_resp_valid_i),
    .err_resp_valid_o (err_resp_valid),
    .err_status_o     (err_status),
    .state_o          (state_o)
  );

  mpu_resp_merge u_merge (
    .bus_resp_valid_i   (bus_resp_valid_i),
    .bus_resp_rdata_i   (bus_resp_rdata_i),
    .err_resp_valid_i   (err_resp_valid),
    .err_status_i       (err_status),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_rdata_o  (core_resp_rdata_o),
    .core_resp_status_o (core_resp_status_o)
  );

endmodule

`default_nettype wire

//--- testbench/mpu_assertions.sv
// Concurrent checks on the transaction gate, bound into every mpu_trans_gate
// fail_cnt counts assertion failures for the final report

`timescale 1ns/1ns
`default_nettype none

module mpu_assertions (
  input wire logic                 clk,
  input wire logic                 rst_n_i,
  input wire logic                 pma_err_i,
  input wire mpu_pkg::memtype_t    pma_memtype_i,
  input wire logic                 bus_req_valid_o,
  input wire mpu_pkg::memtype_t    bus_memtype_o,
  input wire logic                 bus_resp_valid_i,
  input wire logic                 core_req_ready_o,
  input wire logic                 err_resp_valid_o,
  input wire mpu_pkg::mpu_state_e  state_o
);

  int unsigned fail_cnt = 0;

  // Denied requests never reach the bus
  a_no_denied_fwd: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(state_o == mpu_pkg::MPU_IDLE && bus_req_valid_o && pma_err_i))
    else begin
      $error("bus request issued for a denied access");
      fail_cnt++;
    end

  a_no_resp_collision: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(err_resp_valid_o && bus_resp_valid_i))
    else begin
      $error("error response collides with a bus response");
      fail_cnt++;
    end

  // Core is blocked while an error is pending
  a_blocked_when_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    (state_o != mpu_pkg::MPU_IDLE) |-> !core_req_ready_o)
    else begin
      $error("core request ready outside idle state");
      fail_cnt++;
    end

  a_memtype_match: assert property (@(posedge clk) disable iff (!rst_n_i)
    bus_req_valid_o |-> (bus_memtype_o == pma_memtype_i))
    else begin
      $error("bus memtype differs from region attributes");
      fail_cnt++;
    end

endmodule

bind mpu_trans_gate mpu_assertions u_assertions (
  .clk              (clk),
  .rst_n_i          (rst_n_i),
  .pma_err_i        (pma_err_i),
  .pma_memtype_i    (pma_memtype_i),
  .bus_req_valid_o  (bus_req_valid_o),
  .bus_memtype_o    (bus_memtype_o),
  .bus_resp_valid_i (bus_resp_valid_i),
  .core_req_ready_o (core_req_ready_o),
  .err_resp_valid_o (err_resp_valid_o),
  .state_o          (state_o)
);

`default_nettype wire

//--- testbench/mpu_tb.sv
// Testbench for mpu_top with the default four-region PMA table
// Bus model answers in order after 1 to 3 cycles, rdata is address XOR a fixed pattern

`timescale 1ns/1ns
`default_nettype none

module mpu_tb;

  localparam int unsigned CLK_PERIOD      = 8;
  localparam int unsigned RESET_CYCLES    = 16;
  // Below the bus model's three-cycle depth so the limit is actually hit
  localparam int unsigned MAX_OUTSTANDING = 2;
  localparam logic [31:0] SEED            = 32'hcc6c_bb40;
  localparam logic [31:0] RDATA_PATTERN   = 32'h5a5a_c3c3;

  logic clk;
  logic rst_n_i;
  logic core_req_valid_i;
  logic [31:0] core_addr_i;
  logic core_exec_i;
  logic core_atomic_i;
  logic core_we_i;
  logic [31:0] core_wdata_i;
  logic core_req_ready_o;
  logic core_resp_valid_o;
  logic [31:0] core_resp_rdata_o;
  mpu_pkg::mpu_status_e core_resp_status_o;
  logic bus_req_valid_o;
  logic [31:0] bus_addr_o;
  logic [1:0] bus_memtype_o;
  logic bus_we_o;
  logic [31:0] bus_wdata_o;
  logic bus_req_ready_i;
  logic bus_resp_valid_i;
  logic [31:0] bus_resp_rdata_i;
  mpu_pkg::mpu_state_e state_o;

  // Stimulus table, one entry per row in each queue
  logic [31:0] tbl_addr[$];
  logic tbl_exec[$];
  logic tbl_atomic[$];
  logic tbl_we[$];
  mpu_pkg::mpu_status_e tbl_status[$];
  logic [1:0] tbl_memtype[$];

  // Expected core responses in acceptance order
  mpu_pkg::mpu_status_e exp_status_q[$];
  logic [31:0] exp_data_q[$];

  // Bus model state
  logic [31:0] pend_addr[$];
  int unsigned pend_due[$];
  int unsigned cycle;
  int unsigned due;

  int unsigned errors;
  int unsigned total_errors;
  int unsigned allowed_cnt;
  int unsigned bus_hs_cnt;
  int unsigned limit_cycles;

  mpu_top #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) dut0 (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .core_req_valid_i   (core_req_valid_i),
    .core_addr_i        (core_addr_i),
    .core_exec_i        (core_exec_i),
    .core_atomic_i      (core_atomic_i),
    .core_we_i          (core_we_i),
    .core_wdata_i       (core_wdata_i),
    .core_req_ready_o   (core_req_ready_o),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_rdata_o  (core_resp_rdata_o),
    .core_resp_status_o (core_resp_status_o),
    .bus_req_valid_o    (bus_req_valid_o),
    .bus_addr_o         (bus_addr_o),
    .bus_memtype_o      (bus_memtype_o),
    .bus_we_o           (bus_we_o),
    .bus_wdata_o        (bus_wdata_o),
    .bus_req_ready_i    (bus_req_ready_i),
    .bus_resp_valid_i   (bus_resp_valid_i),
    .bus_resp_rdata_i   (bus_resp_rdata_i),
    .state_o            (state_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic add_row(input logic [31:0] addr, input logic exec, input logic atomic,
                         input logic we, input mpu_pkg::mpu_status_e status,
                         input logic [1:0] memtype);
    tbl_addr.push_back(addr);
    tbl_exec.push_back(exec);
    tbl_atomic.push_back(atomic);
    tbl_we.push_back(we);
    tbl_status.push_back(status);
    tbl_memtype.push_back(memtype);
  endtask

  task automatic load_table();
    // Region 0 and the region 0/1 overlap, cacheable
    add_row(32'h0000_0100, 1'b1, 1'b0, 1'b0, mpu_pkg::MPU_OK,          2'b10);
    add_row(32'h0000_9000, 1'b1, 1'b0, 1'b0, mpu_pkg::MPU_OK,          2'b10);
    add_row(32'h0000_c004, 1'b0, 1'b1, 1'b1, mpu_pkg::MPU_OK,          2'b10);
    add_row(32'h0001_2000, 1'b0, 1'b1, 1'b0, mpu_pkg::MPU_OK,          2'b00);
    add_row(32'h0001_4000, 1'b1, 1'b0, 1'b0, mpu_pkg::MPU_ERR_PERM,    2'b00);
    add_row(32'h8000_0010, 1'b0, 1'b1, 1'b0, mpu_pkg::MPU_ERR_PERM,    2'b00);
    add_row(32'h0002_0000, 1'b0, 1'b0, 1'b0, mpu_pkg::MPU_ERR_NOMATCH, 2'b00);
    add_row(32'h4000_0020, 1'b0, 1'b0, 1'b1, mpu_pkg::MPU_OK,          2'b01);
    add_row(32'h4000_0040, 1'b0, 1'b0, 1'b0, mpu_pkg::MPU_OK,          2'b01);
    add_row(32'h0000_0200, 1'b0, 1'b0, 1'b0, mpu_pkg::MPU_OK,          2'b10);
    add_row(32'h0001_8000, 1'b0, 1'b0, 1'b1, mpu_pkg::MPU_OK,          2'b00);
    // Denied while the requests above may still be outstanding
    add_row(32'hc000_0000, 1'b0, 1'b0, 1'b0, mpu_pkg::MPU_ERR_NOMATCH, 2'b00);
    add_row(32'h8000_0100, 1'b0, 1'b0, 1'b0, mpu_pkg::MPU_OK,          2'b00);
    add_row(32'h4000_3ffc, 1'b1, 1'b0, 1'b0, mpu_pkg::MPU_ERR_PERM,    2'b00);
    add_row(32'h0000_fffc, 1'b0, 1'b0, 1'b0, mpu_pkg::MPU_OK,          2'b10);
    add_row(32'h4000_4000, 1'b0, 1'b0, 1'b0, mpu_pkg::MPU_ERR_NOMATCH, 2'b00);
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the handshake edge
  task automatic apply_row(input int idx);
    core_req_valid_i = 1'b1;
    core_addr_i      = tbl_addr[idx];
    core_exec_i      = tbl_exec[idx];
    core_atomic_i    = tbl_atomic[idx];
    core_we_i        = tbl_we[idx];
    core_wdata_i     = ~tbl_addr[idx];
    @(posedge clk);
    while (!core_req_ready_o) @(posedge clk);
    if (tbl_status[idx] == mpu_pkg::MPU_OK) begin
      check_value("bus request valid", 32'(bus_req_valid_o), 32'd1);
      check_value("bus address", bus_addr_o, tbl_addr[idx]);
      check_value("bus memtype", 32'(bus_memtype_o), 32'(tbl_memtype[idx]));
      check_value("bus write enable", 32'(bus_we_o), 32'(tbl_we[idx]));
      check_value("bus write data", bus_wdata_o, ~tbl_addr[idx]);
      allowed_cnt++;
      exp_data_q.push_back(tbl_addr[idx] ^ RDATA_PATTERN);
    end else begin
      check_value("bus request for denied access", 32'(bus_req_valid_o), 32'd0);
      exp_data_q.push_back(32'd0);
    end
    exp_status_q.push_back(tbl_status[idx]);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // Bus responder model
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    cycle            = 0;
    bus_hs_cnt       = 0;
    bus_req_ready_i  = 1'b0;
    bus_resp_valid_i = 1'b0;
    bus_resp_rdata_i = '0;
    forever begin
      @(posedge clk);
      if (bus_req_valid_o && bus_req_ready_i) begin
        due = cycle + 1 + ($urandom % 3);
        // Keep answers in order, one per cycle
        if (pend_due.size() != 0 && due <= pend_due[$]) begin
          due = pend_due[$] + 1;
        end
        pend_addr.push_back(bus_addr_o);
        pend_due.push_back(due);
        bus_hs_cnt++;
        check_value("outstanding limit exceeded",
                    32'(pend_addr.size() > MAX_OUTSTANDING), 32'd0);
      end
      if (bus_resp_valid_i) begin
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      cycle++;
      #1;
      bus_req_ready_i = (($urandom % 4) != 0);
      if (pend_due.size() != 0 && pend_due[0] <= cycle) begin
        bus_resp_valid_i = 1'b1;
        bus_resp_rdata_i = pend_addr[0] ^ RDATA_PATTERN;
      end else begin
        bus_resp_valid_i = 1'b0;
        bus_resp_rdata_i = '0;
      end
    end
  end

  // Scoreboard for core responses
  always @(posedge clk) begin
    if (rst_n_i && core_resp_valid_o) begin
      if (exp_status_q.size() == 0) begin
        $display("[ERROR] %0t: core response arrived with no request pending", $time);
        errors++;
      end else begin
        check_value("response status", 32'(core_resp_status_o),
                    32'(exp_status_q.pop_front()));
        check_value("response data", core_resp_rdata_o, exp_data_q.pop_front());
      end
    end
  end

  // Watchdog
  initial begin
    #1;
    limit_cycles = RESET_CYCLES + tbl_addr.size() * 50;
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout after %0d cycles with %0d responses missing, %0d errors so far",
             limit_cycles, exp_status_q.size(), errors);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    errors           = 0;
    allowed_cnt      = 0;
    rst_n_i          = 1'b0;
    core_req_valid_i = 1'b0;
    core_addr_i      = '0;
    core_exec_i      = 1'b0;
    core_atomic_i    = 1'b0;
    core_we_i        = 1'b0;
    core_wdata_i     = '0;
    load_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n_i = 1'b1;

    // Idle outputs straight after reset
    @(posedge clk);
    check_value("bus request valid after reset", 32'(bus_req_valid_o), 32'd0);
    check_value("core response valid after reset", 32'(core_resp_valid_o), 32'd0);
    check_value("state after reset", 32'(state_o), 32'(mpu_pkg::MPU_IDLE));
    #1;

    for (int i = 0; i < tbl_addr.size(); i++) begin
      apply_row(i);
    end
    core_req_valid_i = 1'b0;

    while (exp_status_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    check_value("bus handshakes vs allowed requests", bus_hs_cnt, allowed_cnt);
    check_value("state at end", 32'(state_o), 32'(mpu_pkg::MPU_IDLE));

    total_errors = errors + dut0.u_gate.u_assertions.fail_cnt;
    $display("Run finished with %0d rows and %0d errors", tbl_addr.size(), total_errors);
    if (total_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mpu.f
hw/mpu_pkg.sv
hw/pma_region_decode.sv
hw/mpu_trans_gate.sv
hw/mpu_resp_merge.sv
hw/mpu_top.sv
testbench/mpu_assertions.sv
testbench/mpu_tb.sv

//--- Makefile
# Verilator flow for the MPU testbench

VERILATOR ?= verilator
VFLAGS    := --timing --assert
TOP       := mpu_tb
FILELIST  := mpu.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "ALL CHECKS PASSED" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
